// File: boot.f
hdl/boot_pkg.sv
hdl/boot_timer.sv
hdl/boot_fsm.sv
hdl/flash_reader.sv
hdl/ramio.sv
hdl/boot_top.sv
sim/boot_models.sv
sim/boot_asserts.sv
sim/boot_tb.sv

// File: Makefile
TOP = boot_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f boot.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// File: sim/boot_tb.sv
module boot_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import boot_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;
  localparam int WAIT_LIMIT   = 400;  // cycles for one host access or command phase
  localparam int BOOT_CYCLES  = STARTUP_WAIT_CYCLES + 64 * SPI_DIV
                                + FLASH_TRANSFER_BYTES * (16 * SPI_DIV + 16);
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + BOOT_CYCLES + 256);

  logic        clk, rst;
  logic        flash_clk, flash_mosi, flash_cs, flash_miso;
  logic        br_cmd_en, br_rd_data_valid;
  br_cmd_t     br_req;
  logic [63:0] br_rd_data;
  logic        host_enable, host_ready, host_busy, boot_done;
  ramio_req_t  host_req;
  logic [31:0] host_data;

  logic [15:0] lfsr;
  logic [7:0]  flash_bytes [0:63];  // expected flash contents
  int          errors, checks, cycles;

  boot_top dut0 (.*);
  flash_model flash0 (.flash_clk, .flash_mosi, .flash_cs, .flash_miso);
  ram_model ram0 (.clk, .br_cmd_en, .br_req, .br_rd_data, .br_rd_data_valid);
  bind ramio boot_asserts ram_checks (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois, taps 16 14 13 11
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);  // one step per bit
    end
    return r;
  endfunction

  function automatic logic [7:0] ram_byte(input int a);
    logic [5:0]  w;
    logic [2:0]  lane;
    logic [63:0] word;
    w    = a[8:3];
    lane = a[2:0];
    word = ram0.mem[w];
    return word[{lane, 3'b000} +: 8];  // lane 0 is the low byte
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic fill_models();
    logic [31:0] bits;
    for (int i = 0; i < 64; i++) begin
      bits           = draw_bits(8);
      flash_bytes[i] = bits[7:0];
      flash0.mem[i]  = bits[7:0];
    end
    for (int i = 0; i < 256; i++) begin
      bits              = draw_bits(2);
      ram0.lat_table[i] = bits[1:0];
    end
  endtask

  task automatic host_access(input ramio_req_t req, output logic [31:0] data,
                             output logic ready);
    int n;
    n = 0;
    while (host_busy && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    host_req    = req;
    host_enable = 1'b1;  // single cycle strobe
    @(negedge clk);
    host_enable = 1'b0;
    n = 0;
    while (host_busy && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (host_busy)
      report_timeout("host access to finish");
    data  = host_data;
    ready = host_ready;  // pulses with busy falling
  endtask

  task automatic host_read(input logic [2:0] rtype, input logic [31:0] addr,
                           output logic [31:0] data);
    ramio_req_t req;
    logic       ready;
    req = '{write_type: WR_NONE, read_type: rtype, address: addr, data: 32'h0};
    host_access(req, data, ready);
    check_value("data_out_ready at end of read", {31'h0, ready}, 32'h1);
  endtask

  task automatic host_write(input logic [1:0] wtype, input logic [31:0] addr,
                            input logic [31:0] data);
    ramio_req_t  req;
    logic [31:0] unused;
    logic        ready;
    req = '{write_type: wtype, read_type: RD_NONE, address: addr, data: data};
    host_access(req, unused, ready);
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic test_reset_state();
    rst = 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_value("outputs in reset", {28'h0, flash_cs, br_cmd_en, host_busy, boot_done}, 32'h8);
    end
    rst    = 1'b0;
    cycles = 0;
    @(posedge clk);
    cycles = 1;
    @(negedge clk);
    check_value("outputs after reset", {28'h0, flash_cs, br_cmd_en, host_busy, boot_done}, 32'h8);
  endtask

  task automatic test_startup_wait();
    while (flash_cs && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end
    check_value("cycles to flash_cs low", cycles, STARTUP_WAIT_CYCLES + 1);
  endtask

  task automatic test_flash_command();
    int n;
    n = 0;
    while (flash0.rise_cnt != 6'd32 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    check_value("flash command bits", flash0.cmd_word, {8'h03, 24'h000000});
  endtask

  task automatic test_copy();
    int         n;
    logic [7:0] exp;
    n = 0;
    while (!boot_done && n < 2 * BOOT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!boot_done)
      report_timeout("boot_done");
    for (int a = 0; a < 24; a++) begin
      exp = (a < FLASH_TRANSFER_BYTES) ? flash_bytes[a] : 8'hA5;  // tail of word 2 untouched
      check_value("ram byte after copy", {24'h0, ram_byte(a)}, {24'h0, exp});
    end
  endtask

  task automatic test_host_reads();
    logic [31:0] d;
    logic [7:0]  b;
    logic [15:0] h;
    int          sb_addr;
    host_read(RD_WORD, 32'd4, d);
    check_value("word read at 4", d, {flash_bytes[7], flash_bytes[6],
                                      flash_bytes[5], flash_bytes[4]});
    sb_addr = 9;
    for (int i = FLASH_TRANSFER_BYTES - 1; i >= 0; i--)
      if (flash_bytes[i][7])
        sb_addr = i;  // first negative byte, if any
    b = flash_bytes[sb_addr];
    host_read(RD_BYTE, sb_addr, d);
    check_value("signed byte read", d, {{24{b[7]}}, b});
    host_read(RD_BYTE_U, sb_addr, d);
    check_value("unsigned byte read", d, {24'h0, b});
    h = {flash_bytes[11], flash_bytes[10]};
    host_read(RD_HALF, 32'd10, d);
    check_value("halfword read at 10", d, {{16{h[15]}}, h});
  endtask

  task automatic test_host_store();
    logic [31:0] d;
    logic [7:0]  v;
    v = ~flash_bytes[2];  // always differs from the old byte
    host_write(WR_BYTE, 32'd2, {24'hFFFFFF, v});
    host_read(RD_WORD, 32'd0, d);
    check_value("word 0 after byte store", d, {flash_bytes[3], v, flash_bytes[1], flash_bytes[0]});
    host_read(RD_WORD, 32'd4, d);
    check_value("word 4 after byte store", d, {flash_bytes[7], flash_bytes[6],
                                               flash_bytes[5], flash_bytes[4]});
  endtask

  // ----------------------------------------------------------
  // sequence, verdict and watchdog
  // ----------------------------------------------------------
  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    host_enable = 1'b0;
    host_req    = '0;
    errors      = 0;
    checks      = 0;
    lfsr        = 16'd23;
    fill_models();
    test_reset_state();
    test_startup_wait();
    test_flash_command();
    test_copy();
    test_host_reads();
    test_host_store();
    repeat (4) @(negedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end
endmodule

// File: sim/boot_asserts.sv
module boot_asserts (
  input logic clk,
  input logic rst,
  input logic enable,
  input logic busy,
  input logic data_out_ready,
  input logic br_cmd_en,
  input logic br_rd_data_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  // requester side
  enable_when_idle: assert property (@(posedge clk) disable iff (rst) enable |-> !busy)
    else $error("ramio enable raised while busy");
  busy_after_enable: assert property (@(posedge clk) disable iff (rst) enable |=> busy)
    else $error("ramio busy did not rise after enable");

  // read completion
  ready_ends_busy: assert property (@(posedge clk) disable iff (rst) data_out_ready |-> !busy)
    else $error("ramio still busy with data_out_ready");

  // burst ram side
  valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
                                    br_rd_data_valid |=> !br_rd_data_valid)
    else $error("br_rd_data_valid longer than one cycle");
  cmd_one_cycle: assert property (@(posedge clk) disable iff (rst) br_cmd_en |=> !br_cmd_en)
    else $error("br_cmd_en longer than one cycle");
endmodule

// File: sim/boot_models.sv
// spi flash, mode 0, answers any command with its data from address 0
module flash_model (
  input  logic flash_clk,
  input  logic flash_mosi,
  input  logic flash_cs,
  output logic flash_miso
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]  mem [0:63];  // loaded by the testbench
  logic [31:0] cmd_word;    // opcode and address as shifted in
  logic [5:0]  rise_cnt;
  logic [8:0]  out_idx;     // data bit position in the stream
  logic        clk_q;

  initial begin
    flash_miso = 1'b0;
    cmd_word   = '0;
    rise_cnt   = '0;
    out_idx    = '0;
    clk_q      = 1'b0;
  end

  always @(flash_clk, flash_cs) begin
    if (flash_cs) begin
      rise_cnt = '0;  // deselected, next select starts over
      out_idx  = '0;
    end else if (flash_clk && !clk_q && rise_cnt < 6'd32) begin
      cmd_word = {cmd_word[30:0], flash_mosi};
      rise_cnt = rise_cnt + 6'd1;
    end else if (!flash_clk && clk_q && rise_cnt == 6'd32) begin
      flash_miso = mem[out_idx[8:3]][~out_idx[2:0]];  // msb first
      out_idx    = out_idx + 9'd1;
    end
    clk_q = flash_clk;
  end
endmodule

// ----------------------------------------------------------
// burst ram, one 64 bit word per command
// ----------------------------------------------------------
module ram_model (
  input  logic              clk,
  input  logic              br_cmd_en,
  input  boot_pkg::br_cmd_t br_req,
  output logic [63:0]       br_rd_data,
  output logic              br_rd_data_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [63:0] mem [0:63];        // low address bits only
  logic [1:0]  lat_table [0:255]; // read latencies, loaded by the testbench
  logic [7:0]  lat_idx;
  logic [1:0]  wait_cnt;
  logic        pending;
  logic [5:0]  rd_addr;

  initial begin
    for (int i = 0; i < 64; i++)
      mem[i] = {8{8'hA5}};
    lat_idx          = '0;
    wait_cnt         = '0;
    pending          = 1'b0;
    rd_addr          = '0;
    br_rd_data       = '0;
    br_rd_data_valid = 1'b0;
  end

  always @(negedge clk) begin
    br_rd_data_valid <= 1'b0;
    if (pending) begin
      if (wait_cnt == 2'd0) begin
        br_rd_data       <= mem[rd_addr];
        br_rd_data_valid <= 1'b1;
        pending          <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
    if (br_cmd_en && br_req.cmd) begin
      mem[br_req.addr[5:0]] = br_req.wr_data;  // write taken at once
    end else if (br_cmd_en) begin
      pending  <= 1'b1;
      wait_cnt <= lat_table[lat_idx];
      lat_idx  <= lat_idx + 8'd1;
      rd_addr  <= br_req.addr[5:0];
    end
  end
endmodule

// File: hdl/boot_top.sv
module boot_top (
  input  logic                 clk,
  input  logic                 rst,
  // spi flash
  output logic                 flash_clk,
  output logic                 flash_mosi,
  output logic                 flash_cs,
  input  logic                 flash_miso,
  // burst ram
  output logic                 br_cmd_en,
  output boot_pkg::br_cmd_t    br_req,
  input  logic [63:0]          br_rd_data,
  input  logic                 br_rd_data_valid,
  // host side of ramio
  input  logic                 host_enable,
  input  boot_pkg::ramio_req_t host_req,
  output logic [31:0]          host_data,
  output logic                 host_ready,
  output logic                 host_busy,
  output logic                 boot_done
);
  import boot_pkg::*;

  logic        start_wait, wait_done, spi_tick, tick_en;
  logic        count_inc, count_clr;
  logic [15:0] byte_count;
  logic        flash_start, flash_next, flash_last, flash_done;
  logic        byte_valid;
  logic [7:0]  byte_data;
  ramio_req_t  fsm_req, mem_req;
  logic        fsm_enable, mem_enable;
  logic        mem_busy, mem_ready;
  logic [31:0] mem_data;

  assign flash_last = (byte_count == 16'(FLASH_TRANSFER_BYTES));  // close flash after this

  // ----------------------------------------------------------
  // ramio owner, sequencer until boot is done
  // ----------------------------------------------------------
  assign mem_enable = boot_done ? host_enable : fsm_enable;
  assign mem_req    = boot_done ? host_req : fsm_req;
  assign host_data  = mem_data;
  assign host_ready = mem_ready && boot_done;
  assign host_busy  = mem_busy;   // host waits out the copy too

  boot_timer timer (.clk, .rst, .start_wait, .wait_done, .spi_tick, .tick_en,
                    .count_inc, .count_clr, .byte_count);

  boot_fsm fsm (.clk, .rst, .wait_done, .byte_count, .start_wait, .count_inc, .count_clr,
                .flash_start, .flash_next, .byte_valid, .byte_data, .flash_done,
                .mem_req(fsm_req), .mem_enable(fsm_enable), .mem_busy, .boot_done);

  flash_reader flash (.clk, .rst, .spi_tick, .start(flash_start), .next(flash_next),
                      .last(flash_last), .byte_valid, .byte_data, .done(flash_done),
                      .tick_en, .flash_clk, .flash_mosi, .flash_cs, .flash_miso);

  ramio ram (.clk, .rst, .enable(mem_enable), .req(mem_req), .data_out(mem_data),
             .data_out_ready(mem_ready), .busy(mem_busy), .br_cmd_en, .br_req,
             .br_rd_data, .br_rd_data_valid);

endmodule

// File: hdl/ramio.sv
module ramio (
  input  logic                 clk,
  input  logic                 rst,
  // load/store port
  input  logic                 enable,
  input  boot_pkg::ramio_req_t req,
  output logic [31:0]          data_out,
  output logic                 data_out_ready,
  output logic                 busy,
  // burst ram
  output logic                 br_cmd_en,
  output boot_pkg::br_cmd_t    br_req,
  input  logic [63:0]          br_rd_data,
  input  logic                 br_rd_data_valid
);
  import boot_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    READ,   // word read issued, waiting on valid
    WRITE   // merged word on the bus
  } state_t;

  state_t     state;
  ramio_req_t req_q;      // request held for the access
  logic [2:0] lane;       // byte within the ram word
  logic [2:0] lane_hi;
  logic       is_write;
  ram_word_u  rd_word;
  ram_word_u  merged;
  logic [7:0] ld_byte;
  logic [15:0] ld_half;
  logic [31:0] ld_value;

  assign lane     = req_q.address[2:0];
  assign lane_hi  = lane + 3'd1;     // halfwords assumed aligned
  assign is_write = (req_q.write_type != WR_NONE);
  assign rd_word  = br_rd_data;
  assign busy     = (state != IDLE);

  // ----------------------------------------------------------
  // store merge into the fetched word
  // ----------------------------------------------------------
  always_comb begin
    merged = rd_word;
    case (req_q.write_type)
      WR_BYTE: merged.lanes[lane] = req_q.data[7:0];
      WR_HALF: begin
        merged.lanes[lane]    = req_q.data[7:0];   // little endian
        merged.lanes[lane_hi] = req_q.data[15:8];
      end
      WR_WORD: merged.words[lane[2]] = req_q.data;
      default: merged = rd_word;
    endcase
  end

  // ----------------------------------------------------------
  // load extraction and extension
  // ----------------------------------------------------------
  always_comb begin
    ld_byte = rd_word.lanes[lane];
    ld_half = {rd_word.lanes[lane_hi], rd_word.lanes[lane]};
    case (req_q.read_type)
      RD_BYTE:   ld_value = {{24{ld_byte[7]}}, ld_byte};
      RD_BYTE_U: ld_value = {24'h000000, ld_byte};
      RD_HALF:   ld_value = {{16{ld_half[15]}}, ld_half};
      RD_HALF_U: ld_value = {16'h0000, ld_half};
      RD_WORD:   ld_value = rd_word.words[lane[2]];
      default:   ld_value = '0;  // no load requested
    endcase
  end

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      br_cmd_en <= 1'b0;
      data_out_ready <= 1'b0;
    end else begin
      br_cmd_en      <= 1'b0;
      data_out_ready <= 1'b0;
      case (state)
        IDLE: begin
          if (enable) begin
            br_cmd_en <= 1'b1;  // always fetch the word first
            state     <= READ;
          end
        end
        READ: begin
          if (br_rd_data_valid) begin
            if (is_write) begin
              br_cmd_en <= 1'b1;  // write back merged word
              state     <= WRITE;
            end else begin
              data_out_ready <= 1'b1;  // busy drops with it
              state          <= IDLE;
            end
          end
        end
        WRITE:   state <= IDLE;  // write accepted at once
        default: state <= IDLE;
      endcase
    end
  end

  // request and command payload
  always_ff @(posedge clk) begin
    if (state == IDLE && enable) begin
      req_q             <= req;
      br_req.cmd        <= 1'b0;
      br_req.addr       <= req.address[3 +: RAM_ADDR_W];  // 8 bytes per word
      br_req.data_mask  <= 8'h00;
    end else if (state == READ && br_rd_data_valid) begin
      br_req.cmd     <= is_write;
      br_req.wr_data <= merged;
      data_out       <= ld_value;
    end
  end

endmodule

// File: hdl/flash_reader.sv
module flash_reader (
  input  logic       clk,
  input  logic       rst,
  input  logic       spi_tick,
  input  logic       start,
  input  logic       next,
  input  logic       last,
  output logic       byte_valid,
  output logic [7:0] byte_data,
  output logic       done,
  output logic       tick_en,
  output logic       flash_clk,
  output logic       flash_mosi,
  output logic       flash_cs,
  input  logic       flash_miso
);
  import boot_pkg::*;

  typedef enum logic [1:0] {IDLE, CMD, RECV, HOLD} state_t;

  state_t      state;
  logic [31:0] shift_out;  // opcode then 24 bit address
  logic [6:0]  shift_in;   // bits of the byte so far
  logic [4:0]  bit_cnt;

  assign tick_en    = (state == CMD) || (state == RECV);  // clock runs only here
  assign flash_mosi = shift_out[31];                      // msb first

  // ----------------------------------------------------------
  // control, spi mode 0
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      flash_cs <= 1'b1;
      flash_clk <= 1'b0;
      done <= 1'b0;
      byte_valid <= 1'b0;
      bit_cnt <= '0;
      shift_out <= '0;
    end else begin
      byte_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            flash_cs  <= 1'b0;
            done      <= 1'b0;
            shift_out <= {FLASH_READ_CMD, 24'h000000};  // read from address 0
            bit_cnt   <= '0;
            state     <= CMD;
          end
        end
        CMD: begin
          if (spi_tick) begin
            flash_clk <= ~flash_clk;
            if (flash_clk) begin  // falling edge, next mosi bit
              shift_out <= {shift_out[30:0], 1'b0};
              bit_cnt   <= bit_cnt + 5'd1;        // wraps to 0 after bit 31
              if (bit_cnt == 5'd31)
                state <= RECV;
            end
          end
        end
        RECV: begin
          if (spi_tick) begin
            flash_clk <= ~flash_clk;
            if (!flash_clk) begin  // rising edge samples miso
              if (bit_cnt == 5'd7) begin
                bit_cnt    <= '0;
                byte_valid <= 1'b1;
              end else begin
                bit_cnt <= bit_cnt + 5'd1;
              end
            end else if (bit_cnt == 5'd0) begin
              state <= HOLD;  // clock low after eighth bit
            end
          end
        end
        HOLD: begin
          if (last) begin
            flash_cs <= 1'b1;
            done     <= 1'b1;
            state    <= IDLE;
          end else if (next) begin
            state <= RECV;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // receive data path
  always_ff @(posedge clk) begin
    if (state == RECV && spi_tick && !flash_clk) begin
      shift_in <= {shift_in[5:0], flash_miso};
      if (bit_cnt == 5'd7)
        byte_data <= {shift_in, flash_miso};
    end
  end

endmodule

// File: hdl/boot_fsm.sv
module boot_fsm (
  input  logic                 clk,
  input  logic                 rst,
  // timer
  input  logic                 wait_done,
  input  logic [15:0]          byte_count,
  output logic                 start_wait,
  output logic                 count_inc,
  output logic                 count_clr,
  // flash reader
  output logic                 flash_start,
  output logic                 flash_next,
  input  logic                 byte_valid,
  input  logic [7:0]           byte_data,
  input  logic                 flash_done,
  // ramio
  output boot_pkg::ramio_req_t mem_req,
  output logic                 mem_enable,
  input  logic                 mem_busy,
  output logic                 boot_done
);
  import boot_pkg::*;

  typedef enum logic [2:0] {
    WAIT,   // startup delay
    OPEN,   // command phase and first byte
    FETCH,  // waiting on a following byte
    STORE,  // hand byte to ramio
    DRAIN,  // ramio read-modify-write in flight
    DONE
  } state_t;

  state_t     state;
  logic [7:0] data_q;    // byte being stored
  logic       copy_end;

  assign copy_end = (byte_count == 16'(FLASH_TRANSFER_BYTES));

  // ----------------------------------------------------------
  // state register
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= WAIT;
    end else begin
      case (state)
        WAIT:  if (wait_done) state <= OPEN;
        OPEN:  if (byte_valid) state <= STORE;
        FETCH: if (byte_valid) state <= STORE;
        STORE: if (!mem_busy) state <= DRAIN;
        DRAIN: begin
          if (!mem_busy) begin
            if (!copy_end)
              state <= FETCH;
            else if (flash_done)  // chip select back up
              state <= DONE;
          end
        end
        DONE:    state <= DONE;   // held until reset
        default: state <= WAIT;
      endcase
    end
  end

  // flash byte capture
  always_ff @(posedge clk) begin
    if (byte_valid)
      data_q <= byte_data;
  end

  // ----------------------------------------------------------
  // outputs
  // ----------------------------------------------------------
  assign start_wait  = (state == WAIT);
  assign flash_start = (state == WAIT) && wait_done;   // single cycle, state moves on
  assign count_clr   = flash_start;
  assign mem_enable  = (state == STORE) && !mem_busy;
  assign count_inc   = mem_enable;                      // address used, step it
  assign flash_next  = (state == DRAIN) && !mem_busy && !copy_end;
  assign boot_done   = (state == DONE);

  // byte store at the running count
  always_comb begin
    mem_req            = '0;
    mem_req.write_type = WR_BYTE;
    mem_req.read_type  = RD_NONE;
    mem_req.address    = {16'h0000, byte_count};
    mem_req.data       = {24'h000000, data_q};
  end

endmodule

// File: hdl/boot_timer.sv
module boot_timer (
  input  logic        clk,
  input  logic        rst,
  input  logic        start_wait,
  output logic        wait_done,
  output logic        spi_tick,
  input  logic        tick_en,
  input  logic        count_inc,
  input  logic        count_clr,
  output logic [15:0] byte_count
);
  import boot_pkg::*;

  logic [15:0] wait_cnt;  // remaining startup cycles
  logic [7:0]  div_cnt;   // spi half period divider

  // ----------------------------------------------------------
  // startup wait, runs down once
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt  <= 16'(STARTUP_WAIT_CYCLES);
      wait_done <= 1'b0;
    end else if (start_wait && !wait_done) begin
      wait_cnt <= wait_cnt - 16'd1;
      if (wait_cnt == 16'd1)
        wait_done <= 1'b1;  // sticks until reset
    end
  end

  // spi clock divider, restarts whenever the reader pauses
  always_ff @(posedge clk) begin
    if (rst || !tick_en)
      div_cnt <= '0;
    else if (spi_tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 8'd1;
  end

  assign spi_tick = tick_en && (div_cnt == 8'(SPI_DIV - 1));  // one clk wide

  // bytes copied so far, also the store address
  always_ff @(posedge clk) begin
    if (rst || count_clr)
      byte_count <= '0;
    else if (count_inc)
      byte_count <= byte_count + 16'd1;
  end

endmodule

// File: hdl/boot_pkg.sv
package boot_pkg;

  // ----------------------------------------------------------
  // build constants
  // ----------------------------------------------------------
  localparam int RAM_ADDR_W           = 21;   // burst ram word address
  localparam int STARTUP_WAIT_CYCLES  = 64;   // clk cycles before first flash access
  localparam int FLASH_TRANSFER_BYTES = 20;   // last ram word only partly filled
  localparam int SPI_DIV              = 2;    // clk cycles per spi half period
  localparam logic [7:0] FLASH_READ_CMD = 8'h03;

  // ramio write_type encoding
  localparam logic [1:0] WR_NONE = 2'd0;
  localparam logic [1:0] WR_BYTE = 2'd1;
  localparam logic [1:0] WR_HALF = 2'd2;
  localparam logic [1:0] WR_WORD = 2'd3;

  // ramio read_type encoding, bit 2 set means zero extend
  localparam logic [2:0] RD_NONE   = 3'd0;
  localparam logic [2:0] RD_BYTE   = 3'd1;
  localparam logic [2:0] RD_HALF   = 3'd2;
  localparam logic [2:0] RD_WORD   = 3'd3;
  localparam logic [2:0] RD_BYTE_U = 3'd5;
  localparam logic [2:0] RD_HALF_U = 3'd6;

  // one load/store request into ramio
  typedef struct packed {
    logic [1:0]  write_type;
    logic [2:0]  read_type;
    logic [31:0] address;     // byte address
    logic [31:0] data;
  } ramio_req_t;

  // one burst ram command
  typedef struct packed {
    logic                  cmd;        // 0 read, 1 write
    logic [RAM_ADDR_W-1:0] addr;
    logic [63:0]           wr_data;
    logic [7:0]            data_mask;  // 0 writes all bytes
  } br_cmd_t;

  // 64 bit ram word, lane 0 is the lowest byte address
  typedef union packed {
    logic [7:0][7:0]  lanes;
    logic [1:0][31:0] words;
  } ram_word_u;

endpackage
